// File: sources.f
+incdir+verilog
verilog/farm_pkg.sv
verilog/sensor_averager.sv
verilog/env_checker.sv
verilog/alarm_output.sv
verilog/farm_monitor_top.sv
verif/farm_monitor_tb.sv

// File: verif/farm_monitor_tb.sv
// ====================
// Testbench for farm_monitor_top: LFSR and directed samples, reference model
// Expected results queue per accepted sample, compared at each level_valid pulse
// ====================
`timescale 1ns/1ps
`include "farm_macros.svh"

module farm_monitor_tb
    import farm_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int LATENCY      = 3;       // ena edge to level_valid
    localparam int SAMPLE_COUNT = 600;     // Upper bound on driven cycles
    localparam logic [15:0] LFSR_SEED = 16'd6324;

    // Expected output set for one accepted sample
    typedef struct packed {
        logic [`FARM_READING_W-1:0] level;
        logic [`FARM_N_SENSORS-1:0] alert;
        logic [`FARM_N_SENSORS-1:0] fault;
        logic                       buzzer;
    } expect_t;

    logic                       clk;
    logic                       rst_n;
    logic                       ena;
    sensor_e                    sensor_sel;
    logic [`FARM_READING_W-1:0] reading;
    logic                       buzzer;
    logic [`FARM_N_SENSORS-1:0] alert_code;
    logic [`FARM_N_SENSORS-1:0] fault_code;
    logic [`FARM_READING_W-1:0] level;
    logic                       level_valid;

    // ====================
    // Reference model state
    // ====================
    logic [7:0] m_hist [`FARM_N_SENSORS][`FARM_HIST_DEPTH];
    int         m_ptr  [`FARM_N_SENSORS];   // Next slot to overwrite
    logic [7:0] m_last [`FARM_N_SENSORS];   // Previous raw reading
    logic [3:0] m_alert;
    logic [3:0] m_fault;
    expect_t    exp_q [$];                  // One entry per accepted sample
    logic [15:0] lfsr_state;

    farm_monitor_top i_farm_monitor_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .ena         (ena),
        .sensor_sel  (sensor_sel),
        .reading     (reading),
        .buzzer      (buzzer),
        .alert_code  (alert_code),
        .fault_code  (fault_code),
        .level       (level),
        .level_valid (level_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    // Reference: new average from the sensor's last four readings, then flags
    function automatic expect_t model_sample(input sensor_e s, input logic [7:0] r);
        expect_t    e;
        int         idx;
        int         total;
        logic [7:0] lo;
        logic [7:0] hi;
        idx = int'(s);
        m_hist[idx][m_ptr[idx]] = r;
        m_ptr[idx] = (m_ptr[idx] + 1) % `FARM_HIST_DEPTH;
        total = 0;
        for (int d = 0; d < `FARM_HIST_DEPTH; d++) begin
            total += m_hist[idx][d];  // Unwritten slots still hold 0
        end
        e.level = 8'(total / `FARM_HIST_DEPTH);
        case (s)
            SENSOR_SOIL:  begin lo = `FARM_SOIL_MIN;  hi = `FARM_SOIL_MAX;  end
            SENSOR_TEMP:  begin lo = `FARM_TEMP_MIN;  hi = `FARM_TEMP_MAX;  end
            SENSOR_HUMID: begin lo = `FARM_HUMID_MIN; hi = `FARM_HUMID_MAX; end
            default:      begin lo = `FARM_LIGHT_MIN; hi = `FARM_LIGHT_MAX; end
        endcase
        m_alert[idx] = (e.level < lo) || (e.level > hi);
        m_fault[idx] = (r == m_last[idx]) || (e.level == `FARM_EXTREME_LO)
                       || (e.level == `FARM_EXTREME_HI);
        m_last[idx] = r;
        e.alert  = m_alert;
        e.fault  = m_fault;
        e.buzzer = (|m_alert) | (|m_fault);
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // ====================
    // Stimulus tasks
    // ====================
    task automatic drive_cycle(input logic en, input sensor_e s, input logic [7:0] r);
        @(negedge clk);
        ena        = en;
        sensor_sel = s;
        reading    = r;
        if (en) exp_q.push_back(model_sample(s, r));  // Accepted at next edge
    endtask

    // ena low with junk on the bus
    task automatic idle_cycles(input int n);
        logic [7:0] sel;
        logic [7:0] rd;
        repeat (n) begin
            take_bits(2, sel);
            take_bits(8, rd);
            drive_cycle(1'b0, sensor_e'(sel[1:0]), rd);
        end
    endtask

    task automatic random_stretch(input int n);
        logic [7:0] en;
        logic [7:0] sel;
        logic [7:0] rd;
        repeat (n) begin
            take_bits(1, en);
            take_bits(2, sel);
            take_bits(8, rd);
            drive_cycle(en[0], sensor_e'(sel[1:0]), rd);
        end
    endtask

    // Four readings averaging to v without repeats
    task automatic avg_burst(input sensor_e s, input logic [7:0] v);
        repeat (2) begin
            drive_cycle(1'b1, s, v - 8'd1);
            drive_cycle(1'b1, s, v + 8'd1);
        end
    endtask

    // Just outside, at and just inside each band edge
    task automatic band_sweep(input sensor_e s, input logic [7:0] lo, input logic [7:0] hi);
        avg_burst(s, lo - 8'd1);
        avg_burst(s, lo);
        avg_burst(s, lo + 8'd1);
        avg_burst(s, hi - 8'd1);
        avg_burst(s, hi);
        avg_burst(s, hi + 8'd1);
    endtask

    // ====================
    // Compare process
    // ====================
    initial begin : compare_outputs
        expect_t            held;      // Last reported set, must hold between pulses
        logic [LATENCY-1:0] acc_hist;  // Acceptances of the last edges, oldest on top
        held     = '0;
        acc_hist = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst_n) begin
                held     = '0;
                acc_hist = '0;
                check_value("level_valid", 32'd0, level_valid);
            end else begin
                check_value("level_valid", acc_hist[LATENCY-1], level_valid);
                if (level_valid) begin
                    if (exp_q.size() == 0) begin
                        $display("Output pulse arrived with no expected sample queued");
                        $display("Verification failed");
                        $fatal(1);
                    end else begin
                        held = exp_q.pop_front();
                    end
                end
                acc_hist = {acc_hist[LATENCY-2:0], ena};
            end
            check_value("level", held.level, level);
            check_value("alert_code", held.alert, alert_code);
            check_value("fault_code", held.fault, fault_code);
            check_value("buzzer", held.buzzer, buzzer);
        end
    end

    initial begin : watchdog
        #((SAMPLE_COUNT + 20) * CLK_PERIOD * 2);
        $display("Timeout: the test sequence did not finish in time");
        $display("Verification failed");
        $fatal(1);
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        ena        = 1'b0;
        sensor_sel = SENSOR_SOIL;
        reading    = '0;
        rst_n      = 1'b0;
        lfsr_state = LFSR_SEED;
        m_alert    = '0;
        m_fault    = '0;
        for (int s = 0; s < `FARM_N_SENSORS; s++) begin
            for (int d = 0; d < `FARM_HIST_DEPTH; d++) m_hist[s][d] = '0;
            m_ptr[s]  = 0;
            m_last[s] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(5);                           // No pulse before first sample

        // Extreme averages on fresh sensors
        drive_cycle(1'b1, SENSOR_HUMID, 8'd2);    // Average 0
        drive_cycle(1'b1, SENSOR_TEMP, 8'd0);     // Stuck on 0 and extreme
        repeat (4) drive_cycle(1'b1, SENSOR_LIGHT, 8'hff);
        idle_cycles(3);

        random_stretch(120);

        // Band edges, back to back
        band_sweep(SENSOR_SOIL, `FARM_SOIL_MIN, `FARM_SOIL_MAX);
        band_sweep(SENSOR_TEMP, `FARM_TEMP_MIN, `FARM_TEMP_MAX);
        band_sweep(SENSOR_HUMID, `FARM_HUMID_MIN, `FARM_HUMID_MAX);
        band_sweep(SENSOR_LIGHT, `FARM_LIGHT_MIN, `FARM_LIGHT_MAX);

        random_stretch(120);

        // Stuck reading with another sensor in between
        drive_cycle(1'b1, SENSOR_SOIL, 8'h55);
        idle_cycles(1);
        drive_cycle(1'b1, SENSOR_TEMP, 8'h30);
        drive_cycle(1'b1, SENSOR_SOIL, 8'h55);
        drive_cycle(1'b1, SENSOR_SOIL, 8'h56);    // Clears again

        random_stretch(150);
        idle_cycles(LATENCY + 2);                 // Drain the pipeline

        if (exp_q.size() != 0) begin
            $display("%0d expected samples never got an output pulse", exp_q.size());
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: verilog/farm_monitor_top.sv
// ====================
// Microgreen environment monitor, three registered stages
// level_valid pulses 3 cycles after each ena edge
// ====================
`timescale 1ns/1ps
`include "farm_macros.svh"

module farm_monitor_top
    import farm_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ena,
    input  sensor_e                    sensor_sel,
    input  logic [`FARM_READING_W-1:0] reading,
    output logic                       buzzer,
    output logic [`FARM_N_SENSORS-1:0] alert_code,
    output logic [`FARM_N_SENSORS-1:0] fault_code,
    output logic [`FARM_READING_W-1:0] level,
    output logic                       level_valid
);

    // ====================
    // Stage links
    // ====================
    avg_sample_t   avg_sample;    // Averager to checker
    check_result_t check_result;  // Checker to output

    sensor_averager i_sensor_averager (
        .clk        (clk),
        .rst_n      (rst_n),
        .ena        (ena),
        .sensor_sel (sensor_sel),
        .reading    (reading),
        .sample     (avg_sample)
    );

    env_checker i_env_checker (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (avg_sample),
        .result (check_result)
    );

    alarm_output i_alarm_output (
        .clk         (clk),
        .rst_n       (rst_n),
        .result      (check_result),
        .buzzer      (buzzer),
        .alert_code  (alert_code),
        .fault_code  (fault_code),
        .level       (level),
        .level_valid (level_valid)
    );

endmodule

// File: verilog/alarm_output.sv
// ====================
// Output stage: codes, buzzer and reported level, held between samples
// ====================
`timescale 1ns/1ps
`include "farm_macros.svh"

module alarm_output
    import farm_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  check_result_t              result,
    output logic                       buzzer,       // Any alert or fault
    output logic [`FARM_N_SENSORS-1:0] alert_code,
    output logic [`FARM_N_SENSORS-1:0] fault_code,
    output logic [`FARM_READING_W-1:0] level,        // Last reported average
    output logic                       level_valid   // One pulse per sample
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buzzer      <= 1'b0;
            alert_code  <= '0;
            fault_code  <= '0;
            level       <= '0;
            level_valid <= 1'b0;
        end else begin
            level_valid <= result.valid;
            if (result.valid) begin
                alert_code <= result.alert;
                fault_code <= result.fault;
                level      <= result.avg;
                buzzer     <= (|result.alert) | (|result.fault);
            end
            // Otherwise everything but the pulse holds
        end
    end

endmodule

// File: verilog/env_checker.sv
// ====================
// Processing stage with band alerts and stuck/extreme faults per sensor
// Flags of a sensor change only when that sensor is sampled
// ====================
`timescale 1ns/1ps
`include "farm_macros.svh"

module env_checker
    import farm_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  avg_sample_t   sample,
    output check_result_t result
);

    localparam int RD_W = `FARM_READING_W;
    localparam int N_S  = `FARM_N_SENSORS;

    // ====================
    // Flag and history state
    // ====================
    logic [RD_W-1:0] last_raw [N_S];   // Previous raw reading per sensor
    logic [N_S-1:0]  alert_q;          // Sticky until next sample of that sensor
    logic [N_S-1:0]  fault_q;
    logic [RD_W-1:0] avg_q;
    logic            valid_q;

    logic [RD_W-1:0] band_min;
    logic [RD_W-1:0] band_max;
    logic            stuck;
    logic            extreme;
    logic [N_S-1:0]  alert_nxt;
    logic [N_S-1:0]  fault_nxt;

    // Band of the sensor being checked
    always_comb begin
        unique case (sample.sensor)
            SENSOR_SOIL: begin
                band_min = `FARM_SOIL_MIN;
                band_max = `FARM_SOIL_MAX;
            end
            SENSOR_TEMP: begin
                band_min = `FARM_TEMP_MIN;
                band_max = `FARM_TEMP_MAX;
            end
            SENSOR_HUMID: begin
                band_min = `FARM_HUMID_MIN;
                band_max = `FARM_HUMID_MAX;
            end
            SENSOR_LIGHT: begin
                band_min = `FARM_LIGHT_MIN;
                band_max = `FARM_LIGHT_MAX;
            end
        endcase
    end

    // New flags where only the sampled sensor's bit moves
    always_comb begin
        stuck   = (sample.raw == last_raw[sample.sensor]);  // Repeat of own last value
        extreme = (sample.avg == `FARM_EXTREME_LO) || (sample.avg == `FARM_EXTREME_HI);

        alert_nxt = alert_q;
        fault_nxt = fault_q;
        alert_nxt[sample.sensor] = (sample.avg < band_min) || (sample.avg > band_max);
        fault_nxt[sample.sensor] = stuck || extreme;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < N_S; s++) begin
                last_raw[s] <= '0;  // First sample compares against 0
            end
            alert_q <= '0;
            fault_q <= '0;
            avg_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= sample.valid;
            if (sample.valid) begin
                alert_q <= alert_nxt;
                fault_q <= fault_nxt;
                avg_q   <= sample.avg;
                last_raw[sample.sensor] <= sample.raw;
            end
        end
    end

    // Result register, one cycle behind the flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result.valid <= valid_q;
            result.alert <= alert_q;
            result.fault <= fault_q;
            result.avg   <= avg_q;
        end
    end

endmodule

// File: verilog/sensor_averager.sv
// ====================
// Input stage: per-sensor history and four-sample running average
// One registered avg_sample_t per ena cycle
// ====================
`timescale 1ns/1ps
`include "farm_macros.svh"

module sensor_averager
    import farm_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ena,         // Sample strobe, no handshake
    input  sensor_e                    sensor_sel,
    input  logic [`FARM_READING_W-1:0] reading,
    output avg_sample_t                sample
);

    localparam int RD_W  = `FARM_READING_W;
    localparam int SUM_W = `FARM_SUM_W;
    localparam int PTR_W = $clog2(`FARM_HIST_DEPTH);

    // ====================
    // Per-sensor state
    // ====================
    logic [RD_W-1:0]  hist   [`FARM_N_SENSORS][`FARM_HIST_DEPTH];
    logic [PTR_W-1:0] wr_ptr [`FARM_N_SENSORS];  // Own pointer per sensor
    logic [SUM_W-1:0] sum    [`FARM_N_SENSORS];  // Running total of history

    logic [RD_W-1:0]  oldest;   // Entry about to be overwritten
    logic [SUM_W-1:0] sum_nxt;  // Sum including the new reading

    // Sum update for the selected sensor
    always_comb begin
        oldest  = hist[sensor_sel][wr_ptr[sensor_sel]];
        sum_nxt = sum[sensor_sel] - SUM_W'(oldest) + SUM_W'(reading);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `FARM_N_SENSORS; s++) begin
                for (int d = 0; d < `FARM_HIST_DEPTH; d++) begin
                    hist[s][d] <= '0;
                end
                wr_ptr[s] <= '0;
                sum[s]    <= '0;
            end
            sample <= '0;
        end else begin
            sample.valid <= ena;  // Single-cycle strobe
            if (ena) begin
                // Oldest slot takes the new reading
                hist[sensor_sel][wr_ptr[sensor_sel]] <= reading;
                sum[sensor_sel]    <= sum_nxt;
                wr_ptr[sensor_sel] <= wr_ptr[sensor_sel] + PTR_W'(1);

                sample.sensor <= sensor_sel;
                sample.raw    <= reading;
                sample.avg    <= RD_W'(sum_nxt >> PTR_W);  // Divide by depth
            end
        end
    end

endmodule

// File: verilog/farm_pkg.sv
// ====================
// Types shared by the farm monitor stages and its testbench
// ====================
`include "farm_macros.svh"

package farm_pkg;

    // Sensor selected on the shared reading bus
    typedef enum logic [1:0] {
        SENSOR_SOIL  = 2'd0,
        SENSOR_TEMP  = 2'd1,
        SENSOR_HUMID = 2'd2,
        SENSOR_LIGHT = 2'd3
    } sensor_e;

    // Averager to checker
    typedef struct packed {
        logic                         valid;  // One cycle per accepted sample
        sensor_e                      sensor;
        logic [`FARM_READING_W-1:0]   raw;    // Reading as received
        logic [`FARM_READING_W-1:0]   avg;    // New four-sample average
    } avg_sample_t;

    // Checker to output stage
    // Bit n of alert and fault belongs to sensor n
    typedef struct packed {
        logic                         valid;
        logic [`FARM_N_SENSORS-1:0]   alert;  // Average out of band
        logic [`FARM_N_SENSORS-1:0]   fault;  // Stuck or extreme
        logic [`FARM_READING_W-1:0]   avg;    // Level of sensor just sampled
    } check_result_t;

endpackage

// File: verilog/farm_macros.svh
// ====================
// Widths, history depth and sensor bands for the farm monitor
// Include in the package and in every RTL file
// ====================
`ifndef FARM_MACROS_SVH
`define FARM_MACROS_SVH

// ====================
// Datapath sizes
// ====================
`define FARM_READING_W  8   // One reading on the sensor bus
`define FARM_SUM_W      10  // Four 8-bit samples fit without overflow
`define FARM_HIST_DEPTH 4   // Samples in the running average
`define FARM_N_SENSORS  4   // Soil, temp, humidity, light

// ====================
// Allowed average bands, pea microgreens
// ====================
`define FARM_SOIL_MIN   8'd140  // Too dry below
`define FARM_SOIL_MAX   8'd210  // Too wet above
`define FARM_TEMP_MIN   8'd100
`define FARM_TEMP_MAX   8'd160
`define FARM_HUMID_MIN  8'd120
`define FARM_HUMID_MAX  8'd190
`define FARM_LIGHT_MIN  8'd80   // Too dark
`define FARM_LIGHT_MAX  8'd220  // Too bright

// Averages a healthy sensor never settles on
`define FARM_EXTREME_LO 8'd0
`define FARM_EXTREME_HI 8'd255

`endif
